//--- src/rvfi_chk_pkg.sv
package rvfi_chk_pkg;

  // intr word is compared as a whole and reported through its cause
  typedef struct packed {
    logic [7:0] cause;
    logic       interrupt;
    logic       exception;
    logic       taken;
  } intr_fields_t;

  typedef union packed {
    logic [10:0]  raw;
    intr_fields_t fields;
  } rvfi_intr_u;

  // one retirement with mask widths already cut down to four bits
  typedef struct packed {
    logic        valid;
    logic [31:0] pc_rdata;
    logic [31:0] insn;
    logic [31:0] pc_wdata;
    logic        trap;
    logic        halt;
    logic        dbg;
    logic        nmip;
    logic        dbg_mode;
    rvfi_intr_u  intr;
    logic [1:0]  mode;
    logic [4:0]  rd1_addr;
    logic [31:0] rd1_wdata;
    logic [31:0] mem_addr;
    logic [31:0] mem_rdata;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_rmask;
    logic [3:0]  mem_wmask;
  } rvfi_rec_t;

  // bit positions in the difference bitmap
  typedef enum logic [4:0] {
    FLD_VALID     = 5'd0,
    FLD_PC_RDATA  = 5'd1,
    FLD_INSN      = 5'd2,
    FLD_TRAP      = 5'd3,
    FLD_HALT      = 5'd4,
    FLD_DBG       = 5'd5,
    FLD_DBG_MODE  = 5'd6,
    FLD_NMIP      = 5'd7,
    FLD_INTR      = 5'd8,
    FLD_MODE      = 5'd9,
    FLD_RD1_ADDR  = 5'd10,
    FLD_RD1_WDATA = 5'd11,
    FLD_PC_WDATA  = 5'd12,
    FLD_MEM_RMASK = 5'd13,
    FLD_MEM_WMASK = 5'd14,
    FLD_MEM_ADDR  = 5'd15,
    FLD_MEM_WDATA = 5'd16,
    FLD_MEM_RDATA = 5'd17
  } field_e;

  localparam int unsigned FIELD_CNT = 18;

  typedef logic [FIELD_CNT-1:0] field_map_t;

  // registered output of one comparator
  typedef struct packed {
    logic        hit;
    field_map_t  diff;
    logic [31:0] seq;
    logic [31:0] pc;
    logic [7:0]  cause;
  } cmp_res_t;

  typedef struct packed {
    logic [31:0] seq;
    logic [31:0] pc;
    field_map_t  diff;
    logic [7:0]  cause;
  } mismatch_rec_t;

endpackage

//--- src/rvfi_align.sv
`timescale 1ns/1ps

module rvfi_align
  import rvfi_chk_pkg::*;
#(
  parameter int unsigned ALIGN_DEPTH = 1
) (
  input  logic        rvfi_core,
  input  logic        rst_n_i,
  input  rvfi_rec_t   core_rec_i,
  output rvfi_rec_t   aligned_rec_o,
  output logic [31:0] seq_o
);

  // record payload
  rvfi_rec_t              chain_q [ALIGN_DEPTH];
  // valid bits of the chain
  logic [ALIGN_DEPTH-1:0] valid_q;
  logic [31:0]            seq_q;

  always_ff @(posedge rvfi_core) begin
    chain_q[0] <= core_rec_i;
    for (int i = 1; i < ALIGN_DEPTH; i++) begin
      chain_q[i] <= chain_q[i-1];
    end
  end

  always_ff @(posedge rvfi_core or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= core_rec_i.valid;
      for (int i = 1; i < ALIGN_DEPTH; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // the valid bit comes from the reset chain
  always_comb begin
    aligned_rec_o       = chain_q[ALIGN_DEPTH-1];
    aligned_rec_o.valid = valid_q[ALIGN_DEPTH-1];
  end

  // number of retirements already passed out of the chain
  always_ff @(posedge rvfi_core or negedge rst_n_i) begin
    if (!rst_n_i) begin
      seq_q <= '0;
    end else if (valid_q[ALIGN_DEPTH-1]) begin
      seq_q <= seq_q + 32'd1;
    end
  end

  assign seq_o = seq_q;

endmodule

//--- src/rvfi_ctrl_cmp.sv
`timescale 1ns/1ps

module rvfi_ctrl_cmp
  import rvfi_chk_pkg::*;
(
  input  logic        rvfi_core,
  input  logic        rst_n_i,
  input  rvfi_rec_t   core_rec_i,
  input  rvfi_rec_t   rm_rec_i,
  input  logic [31:0] seq_i,
  output cmp_res_t    res_o
);

  logic        hit_d;
  field_map_t  diff_d;
  logic        hit_q;
  field_map_t  diff_q;
  logic [31:0] seq_q;
  logic [31:0] pc_q;
  logic [7:0]  cause_q;

  // a retirement on either side counts, the reference one decides
  assign hit_d = rm_rec_i.valid | core_rec_i.valid;

  always_comb begin
    diff_d = '0;
    // core retired, reference did not
    diff_d[FLD_VALID] = core_rec_i.valid & ~rm_rec_i.valid;
    if (rm_rec_i.valid) begin
      diff_d[FLD_PC_RDATA] = rm_rec_i.pc_rdata != core_rec_i.pc_rdata;
      diff_d[FLD_INSN]     = rm_rec_i.insn != core_rec_i.insn;
      diff_d[FLD_TRAP]     = rm_rec_i.trap != core_rec_i.trap;
      diff_d[FLD_HALT]     = rm_rec_i.halt != core_rec_i.halt;
      diff_d[FLD_DBG]      = rm_rec_i.dbg != core_rec_i.dbg;
      diff_d[FLD_DBG_MODE] = rm_rec_i.dbg_mode != core_rec_i.dbg_mode;
      diff_d[FLD_NMIP]     = rm_rec_i.nmip != core_rec_i.nmip;
      diff_d[FLD_INTR]     = rm_rec_i.intr.raw != core_rec_i.intr.raw;
      diff_d[FLD_MODE]     = rm_rec_i.mode != core_rec_i.mode;
      diff_d[FLD_RD1_ADDR] = rm_rec_i.rd1_addr != core_rec_i.rd1_addr;
      diff_d[FLD_PC_WDATA] = rm_rec_i.pc_wdata != core_rec_i.pc_wdata;
      // x0 writes carry no meaningful data
      if (rm_rec_i.rd1_addr != 5'd0) begin
        diff_d[FLD_RD1_WDATA] = rm_rec_i.rd1_wdata != core_rec_i.rd1_wdata;
      end
    end
  end

  always_ff @(posedge rvfi_core or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hit_q  <= 1'b0;
      diff_q <= '0;
    end else begin
      hit_q  <= hit_d;
      diff_q <= diff_d;
    end
  end

  // report context taken from the core side
  always_ff @(posedge rvfi_core) begin
    seq_q   <= seq_i;
    pc_q    <= core_rec_i.pc_rdata;
    cause_q <= core_rec_i.intr.fields.cause;
  end

  always_comb begin
    res_o.hit   = hit_q;
    res_o.diff  = diff_q;
    res_o.seq   = seq_q;
    res_o.pc    = pc_q;
    res_o.cause = cause_q;
  end

endmodule

//--- src/rvfi_mem_cmp.sv
`timescale 1ns/1ps

module rvfi_mem_cmp
  import rvfi_chk_pkg::*;
(
  input  logic      rvfi_core,
  input  logic      rst_n_i,
  input  rvfi_rec_t core_rec_i,
  input  rvfi_rec_t rm_rec_i,
  output cmp_res_t  res_o
);

  logic       core_rd;
  logic       core_wr;
  field_map_t diff_d;
  logic       hit_q;
  field_map_t diff_q;

  // access enables follow the core masks
  assign core_rd = |core_rec_i.mem_rmask;
  assign core_wr = |core_rec_i.mem_wmask;

  always_comb begin
    diff_d = '0;
    if (rm_rec_i.valid) begin
      diff_d[FLD_MEM_RMASK] = rm_rec_i.mem_rmask != core_rec_i.mem_rmask;
      diff_d[FLD_MEM_WMASK] = rm_rec_i.mem_wmask != core_rec_i.mem_wmask;
      if (core_rd || core_wr) begin
        diff_d[FLD_MEM_ADDR] = rm_rec_i.mem_addr != core_rec_i.mem_addr;
      end
      if (core_wr) begin
        diff_d[FLD_MEM_WDATA] = rm_rec_i.mem_wdata != core_rec_i.mem_wdata;
      end
      if (core_rd) begin
        diff_d[FLD_MEM_RDATA] = rm_rec_i.mem_rdata != core_rec_i.mem_rdata;
      end
    end
  end

  always_ff @(posedge rvfi_core or negedge rst_n_i) begin
    if (!rst_n_i) begin
      hit_q  <= 1'b0;
      diff_q <= '0;
    end else begin
      hit_q  <= rm_rec_i.valid | core_rec_i.valid;
      diff_q <= diff_d;
    end
  end

  // context fields come from the control comparator
  always_comb begin
    res_o       = '0;
    res_o.hit   = hit_q;
    res_o.diff  = diff_q;
  end

endmodule

//--- src/rvfi_mismatch_report.sv
`timescale 1ns/1ps

module rvfi_mismatch_report
  import rvfi_chk_pkg::*;
(
  input  logic          rvfi_core,
  input  logic          rst_n_i,
  input  cmp_res_t      ctrl_res_i,
  input  cmp_res_t      mem_res_i,
  output mismatch_rec_t rpt_o,
  output logic          rpt_req_o,
  input  logic          rpt_ack_i,
  output logic [15:0]   mismatch_cnt_o,
  output logic [15:0]   drop_cnt_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_ACK_LOW
  } rpt_state_e;

  rpt_state_e    state_q;
  rpt_state_e    state_d;
  field_map_t    diff_all;
  logic          mismatch;
  logic          accept;
  mismatch_rec_t rpt_q;
  logic [15:0]   mismatch_cnt_q;
  logic [15:0]   drop_cnt_q;

  // both comparators see the same retirement in the same cycle
  assign diff_all = ctrl_res_i.diff | mem_res_i.diff;
  assign mismatch = (ctrl_res_i.hit | mem_res_i.hit) & (|diff_all);

  // a new report is only taken while idle
  assign accept = mismatch && (state_q == ST_IDLE);

  // four-phase handshake
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (mismatch) begin
          state_d = ST_REQ;
        end
      end
      ST_REQ: begin
        if (rpt_ack_i) begin
          state_d = ST_ACK_LOW;
        end
      end
      ST_ACK_LOW: begin
        // receiver must release ack before the next request
        if (!rpt_ack_i) begin
          state_d = ST_IDLE;
        end
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge rvfi_core or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // report held stable while req is up
  always_ff @(posedge rvfi_core) begin
    if (accept) begin
      rpt_q.seq   <= ctrl_res_i.seq;
      rpt_q.pc    <= ctrl_res_i.pc;
      rpt_q.diff  <= diff_all;
      rpt_q.cause <= ctrl_res_i.cause;
    end
  end

  always_ff @(posedge rvfi_core or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mismatch_cnt_q <= '0;
      drop_cnt_q     <= '0;
    end else if (mismatch) begin
      mismatch_cnt_q <= mismatch_cnt_q + 16'd1;
      if (!accept) begin
        drop_cnt_q <= drop_cnt_q + 16'd1;
      end
    end
  end

  assign rpt_o          = rpt_q;
  assign rpt_req_o      = (state_q == ST_REQ);
  assign mismatch_cnt_o = mismatch_cnt_q;
  assign drop_cnt_o     = drop_cnt_q;

endmodule

//--- src/rvfi_checker_top.sv
`timescale 1ns/1ps

module rvfi_checker_top
  import rvfi_chk_pkg::*;
#(
  parameter int unsigned ALIGN_DEPTH = 1
) (
  input  logic          rvfi_core,
  input  logic          rst_n_i,
  input  rvfi_rec_t     core_rec_i,
  input  rvfi_rec_t     rm_rec_i,
  output mismatch_rec_t rpt_o,
  output logic          rpt_req_o,
  input  logic          rpt_ack_i,
  output logic [15:0]   mismatch_cnt_o,
  output logic [15:0]   drop_cnt_o
);

  rvfi_rec_t   aligned_rec;
  logic [31:0] seq;
  cmp_res_t    ctrl_res;
  cmp_res_t    mem_res;

  // core stream delayed to meet the reference stream
  rvfi_align #(
    .ALIGN_DEPTH(ALIGN_DEPTH)
  ) rvfi_align_i (
    .rvfi_core    (rvfi_core),
    .rst_n_i      (rst_n_i),
    .core_rec_i   (core_rec_i),
    .aligned_rec_o(aligned_rec),
    .seq_o        (seq)
  );

  rvfi_ctrl_cmp rvfi_ctrl_cmp_i (
    .rvfi_core (rvfi_core),
    .rst_n_i   (rst_n_i),
    .core_rec_i(aligned_rec),
    .rm_rec_i  (rm_rec_i),
    .seq_i     (seq),
    .res_o     (ctrl_res)
  );

  rvfi_mem_cmp rvfi_mem_cmp_i (
    .rvfi_core (rvfi_core),
    .rst_n_i   (rst_n_i),
    .core_rec_i(aligned_rec),
    .rm_rec_i  (rm_rec_i),
    .res_o     (mem_res)
  );

  rvfi_mismatch_report rvfi_mismatch_report_i (
    .rvfi_core     (rvfi_core),
    .rst_n_i       (rst_n_i),
    .ctrl_res_i    (ctrl_res),
    .mem_res_i     (mem_res),
    .rpt_o         (rpt_o),
    .rpt_req_o     (rpt_req_o),
    .rpt_ack_i     (rpt_ack_i),
    .mismatch_cnt_o(mismatch_cnt_o),
    .drop_cnt_o    (drop_cnt_o)
  );

endmodule

//--- testbench/tb_rvfi_checker.sv
`timescale 1ns/1ps

module tb_rvfi_checker
  import rvfi_chk_pkg::*;
();

  localparam int NUM_REC       = 240;
  localparam int MAX_ACK_DELAY = 20;
  // each record may sit through a full handshake plus pipeline drain
  localparam int CYCLE_LIMIT   = NUM_REC * (2 * MAX_ACK_DELAY + 8) + 200;

  logic          rvfi_core;
  logic          rst_n_i;
  rvfi_rec_t     core_rec_i;
  rvfi_rec_t     rm_rec_i;
  mismatch_rec_t rpt_o;
  logic          rpt_req_o;
  logic          rpt_ack_i = 1'b0;
  logic [15:0]   mismatch_cnt_o;
  logic [15:0]   drop_cnt_o;

  logic [15:0]   lfsr_q;
  rvfi_rec_t     rm_pipe [2];
  mismatch_rec_t exp_q [$];
  mismatch_rec_t exp_rpt;
  logic [31:0]   core_seq;
  logic [15:0]   exp_mismatch;
  logic [15:0]   exp_drop;
  int            ack_delay;
  int            wait_cnt;
  int            cycle_cnt = 0;
  int            val_err;
  int            rpt_err = 0;
  int            sva_err = 0;
  logic          req_seen_q;
  logic          quiet;

  rvfi_checker_top #(
    .ALIGN_DEPTH(2)
  ) rvfi_checker_top_i (
    .rvfi_core     (rvfi_core),
    .rst_n_i       (rst_n_i),
    .core_rec_i    (core_rec_i),
    .rm_rec_i      (rm_rec_i),
    .rpt_o         (rpt_o),
    .rpt_req_o     (rpt_req_o),
    .rpt_ack_i     (rpt_ack_i),
    .mismatch_cnt_o(mismatch_cnt_o),
    .drop_cnt_o    (drop_cnt_o)
  );

  always #5 rvfi_core = ~rvfi_core;

  always @(posedge rvfi_core) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, the checker never went idle", cycle_cnt);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // fibonacci lfsr on x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic value_ok(input string name, input logic [31:0] got,
                                    input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED t=%0t %s: got 0x%0h expected 0x%0h", $time, name, got, exp);
      return 1'b0;
    end
    return 1'b1;
  endfunction

  function automatic rvfi_rec_t corrupt(input rvfi_rec_t r, input field_e f);
    rvfi_rec_t c;
    c = r;
    case (f)
      FLD_PC_RDATA:  c.pc_rdata  = r.pc_rdata ^ 32'h4;
      FLD_INSN:      c.insn      = r.insn ^ 32'h0010_0000;
      FLD_TRAP:      c.trap      = ~r.trap;
      FLD_HALT:      c.halt      = ~r.halt;
      FLD_DBG:       c.dbg       = ~r.dbg;
      FLD_DBG_MODE:  c.dbg_mode  = ~r.dbg_mode;
      FLD_NMIP:      c.nmip      = ~r.nmip;
      FLD_INTR:      c.intr.raw  = r.intr.raw ^ 11'h1;
      FLD_MODE:      c.mode      = r.mode ^ 2'b01;
      FLD_RD1_ADDR:  c.rd1_addr  = r.rd1_addr ^ 5'h1;
      FLD_RD1_WDATA: c.rd1_wdata = r.rd1_wdata ^ 32'h1;
      FLD_PC_WDATA:  c.pc_wdata  = r.pc_wdata ^ 32'h8;
      FLD_MEM_RMASK: c.mem_rmask = r.mem_rmask ^ 4'h1;
      FLD_MEM_WMASK: c.mem_wmask = r.mem_wmask ^ 4'h1;
      FLD_MEM_ADDR:  c.mem_addr  = r.mem_addr ^ 32'h10;
      FLD_MEM_WDATA: c.mem_wdata = r.mem_wdata ^ 32'h1;
      FLD_MEM_RDATA: c.mem_rdata = r.mem_rdata ^ 32'h1;
      default:       c.valid     = ~r.valid;
    endcase
    return c;
  endfunction

  task automatic build_rec(output rvfi_rec_t r);
    logic [31:0] v;
    r           = '0;
    r.valid     = 1'b1;
    r.pc_rdata  = take_bits(32);
    r.insn      = take_bits(32);
    r.pc_wdata  = take_bits(32);
    v           = take_bits(5);
    r.trap      = v[0];
    r.halt      = v[1];
    r.dbg       = v[2];
    r.nmip      = v[3];
    r.dbg_mode  = v[4];
    v           = take_bits(11);
    r.intr.raw  = v[10:0];
    v           = take_bits(2);
    r.mode      = v[1:0];
    v           = take_bits(5);
    r.rd1_addr  = v[4:0];
    r.rd1_wdata = take_bits(32);
    r.mem_addr  = take_bits(32);
    r.mem_rdata = take_bits(32);
    r.mem_wdata = take_bits(32);
    v           = take_bits(8);
    r.mem_rmask = v[3:0];
    r.mem_wmask = v[7:4];
  endtask

  // reference copy trails the core record by two cycles
  task automatic drive(input rvfi_rec_t core, input rvfi_rec_t rm);
    @(negedge rvfi_core);
    rm_rec_i   = rm_pipe[1];
    rm_pipe[1] = rm_pipe[0];
    rm_pipe[0] = rm;
    core_rec_i = core;
  endtask

  task automatic retire(input rvfi_rec_t core, input rvfi_rec_t rm, input field_map_t diff,
                        input logic reported);
    mismatch_rec_t e;
    logic [10:0]   intr_shift;
    if (diff != '0) begin
      intr_shift   = core.intr.raw >> 3;
      e.seq        = core_seq;
      e.pc         = core.pc_rdata;
      e.diff       = diff;
      e.cause      = intr_shift[7:0];
      exp_mismatch = exp_mismatch + 16'd1;
      if (reported) begin
        exp_q.push_back(e);
      end else begin
        exp_drop = exp_drop + 16'd1;
      end
    end
    if (core.valid) begin
      core_seq = core_seq + 32'd1;
    end
    drive(core, rm);
  endtask

  task automatic wait_idle();
    rvfi_rec_t idle;
    logic      done;
    idle = '0;
    done = 1'b0;
    repeat (4) drive(idle, idle);
    while (!done) begin
      drive(idle, idle);
      @(posedge rvfi_core);
      done = (exp_q.size() == 0) && !rpt_req_o && !rpt_ack_i;
    end
  endtask

  task automatic check_counters();
    if (!value_ok("mismatch_cnt_o", {16'd0, mismatch_cnt_o}, {16'd0, exp_mismatch})) begin
      val_err++;
    end
    if (!value_ok("drop_cnt_o", {16'd0, drop_cnt_o}, {16'd0, exp_drop})) begin
      val_err++;
    end
  endtask

  // ack responder and report check on each rising req
  always @(negedge rvfi_core) begin
    if (!rst_n_i) begin
      rpt_ack_i  <= 1'b0;
      wait_cnt   = 0;
      req_seen_q = 1'b0;
    end else begin
      if (rpt_req_o && !req_seen_q) begin
        if (exp_q.size() == 0) begin
          $display("unexpected report request at t=%0t", $time);
          rpt_err++;
        end else begin
          exp_rpt = exp_q.pop_front();
          if (!value_ok("rpt_o.seq", rpt_o.seq, exp_rpt.seq)) rpt_err++;
          if (!value_ok("rpt_o.pc", rpt_o.pc, exp_rpt.pc)) rpt_err++;
          if (!value_ok("rpt_o.diff", {14'd0, rpt_o.diff}, {14'd0, exp_rpt.diff})) rpt_err++;
          if (!value_ok("rpt_o.cause", {24'd0, rpt_o.cause}, {24'd0, exp_rpt.cause})) rpt_err++;
        end
      end
      req_seen_q = rpt_req_o;
      if (rpt_req_o && !rpt_ack_i) begin
        if (wait_cnt >= ack_delay) begin
          rpt_ack_i <= 1'b1;
          wait_cnt  = 0;
        end else begin
          wait_cnt++;
        end
      end else if (!rpt_req_o && rpt_ack_i) begin
        // ack is released as slowly as it was raised
        if (wait_cnt >= ack_delay) begin
          rpt_ack_i <= 1'b0;
          wait_cnt  = 0;
        end else begin
          wait_cnt++;
        end
      end
    end
  end

  ack_low_before_req: assert property (@(posedge rvfi_core) disable iff (!rst_n_i)
    $rose(rpt_req_o) |-> !$past(rpt_ack_i))
    else begin
      sva_err++;
      $display("rpt_req_o rose at t=%0t before ack had fallen", $time);
    end

  rpt_stable: assert property (@(posedge rvfi_core) disable iff (!rst_n_i)
    (rpt_req_o && $past(rpt_req_o)) |-> $stable(rpt_o))
    else begin
      sva_err++;
      $display("rpt_o changed at t=%0t while req was held high", $time);
    end

  reset_state: assert property (@(posedge rvfi_core)
    !rst_n_i |-> (!rpt_req_o && mismatch_cnt_o == 16'd0 && drop_cnt_o == 16'd0))
    else begin
      sva_err++;
      $display("outputs not cleared during reset at t=%0t", $time);
    end

  // matching streams must stay silent
  quiet_stream: assert property (@(posedge rvfi_core) disable iff (!rst_n_i)
    quiet |-> (!rpt_req_o && mismatch_cnt_o == 16'd0))
    else begin
      sva_err++;
      $display("report or mismatch count seen on a matching stream at t=%0t", $time);
    end

  initial begin
    field_map_t  m;
    rvfi_rec_t   base;
    rvfi_rec_t   rm;
    rvfi_rec_t   idle;
    field_e      f;
    logic [31:0] v;
    rvfi_core    = 1'b0;
    rst_n_i      = 1'b0;
    core_rec_i   = '0;
    rm_rec_i     = '0;
    rm_pipe[0]   = '0;
    rm_pipe[1]   = '0;
    lfsr_q       = 16'd11888;
    core_seq     = '0;
    exp_mismatch = '0;
    exp_drop     = '0;
    ack_delay    = 0;
    val_err      = 0;
    quiet        = 1'b0;
    idle         = '0;
    repeat (16) @(posedge rvfi_core);
    @(negedge rvfi_core);
    rst_n_i = 1'b1;
    if (!value_ok("rpt_req_o", {31'd0, rpt_req_o}, 32'd0)) val_err++;
    check_counters();

    // random matching stream with gaps
    quiet = 1'b1;
    for (int i = 0; i < 200; i++) begin
      v = take_bits(2);
      if (v[1:0] == 2'd0) drive(idle, idle);
      build_rec(base);
      retire(base, base, '0, 1'b0);
    end
    wait_idle();
    check_counters();
    @(negedge rvfi_core);
    quiet = 1'b0;

    // control and write-back fields one at a time
    for (int i = 1; i <= 12; i++) begin
      f = field_e'(i);
      build_rec(base);
      base.rd1_addr[0] = 1'b1;
      ack_delay = i % 4;
      m = '0;
      m[f] = 1'b1;
      retire(base, corrupt(base, f), m, 1'b1);
      wait_idle();
    end
    check_counters();

    // differences hidden by the mask rules
    build_rec(base);
    base.rd1_addr = 5'd0;
    retire(base, corrupt(base, FLD_RD1_WDATA), '0, 1'b0);
    build_rec(base);
    base.mem_rmask = 4'h0;
    base.mem_wmask = 4'h0;
    retire(base, corrupt(base, FLD_MEM_ADDR), '0, 1'b0);
    build_rec(base);
    base.mem_rmask = 4'h0;
    base.mem_wmask = 4'h3;
    retire(base, corrupt(base, FLD_MEM_RDATA), '0, 1'b0);
    wait_idle();
    check_counters();

    // memory fields with their masks enabled
    for (int i = 13; i <= 17; i++) begin
      f = field_e'(i);
      build_rec(base);
      base.mem_rmask = 4'hf;
      base.mem_wmask = 4'hf;
      m = '0;
      m[f] = 1'b1;
      retire(base, corrupt(base, f), m, 1'b1);
      wait_idle();
    end
    check_counters();

    // core retires, reference does not
    build_rec(base);
    rm = base;
    rm.valid = 1'b0;
    m = '0;
    m[FLD_VALID] = 1'b1;
    retire(base, rm, m, 1'b1);
    wait_idle();
    check_counters();

    // slow receiver drops the two later mismatches
    ack_delay = MAX_ACK_DELAY;
    for (int i = 0; i < 2; i++) begin
      build_rec(base);
      m = '0;
      m[FLD_INSN] = 1'b1;
      retire(base, corrupt(base, FLD_INSN), m, i == 0);
    end
    // third one arrives after req fell while ack is still high
    while (!rpt_ack_i) begin
      drive(idle, idle);
    end
    build_rec(base);
    m = '0;
    m[FLD_INSN] = 1'b1;
    retire(base, corrupt(base, FLD_INSN), m, 1'b0);
    wait_idle();
    ack_delay = 0;
    check_counters();

    $display("error summary: %0d value errors, %0d report errors, %0d assertion failures",
             val_err, rpt_err, sva_err);
    if (val_err == 0 && rpt_err == 0 && sva_err == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- sources.f
src/rvfi_chk_pkg.sv
src/rvfi_align.sv
src/rvfi_ctrl_cmp.sv
src/rvfi_mem_cmp.sv
src/rvfi_mismatch_report.sv
src/rvfi_checker_top.sv
testbench/tb_rvfi_checker.sv

//--- Makefile
TOP := tb_rvfi_checker

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f

# the run passes only if the pass message shows up in the output
run: compile
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
